/* common/cmd_pkg.sv */
// Host command protocol definitions
// Stream byte and reply word types, the 8-byte command buffer,
// the opcodes and the fixed reply codes, and the control FSM states
package cmd_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [31:0] word_t;

	localparam int CMD_BYTES = 8;

	// byte 0 is the opcode
	typedef byte_t [CMD_BYTES-1:0] cmd_buf_t;

	typedef enum logic [7:0] {
		OP_PLL_RESET = 8'd1,
		OP_VERSION   = 8'd2,
		OP_SPI       = 8'd3,
		OP_SPARE     = 8'd4
	} opcode_e;

	localparam word_t REPLY_PLL_RESET = 32'd33;
	localparam word_t REPLY_SPARE     = 32'd19;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DECODE,
		ST_SPI_WAIT,
		ST_REPLY
	} ctrl_state_e;

endpackage

/* common/spi_pkg.sv */
// SPI sequencer definitions
// Chip index type, sequencer states and the short-transfer length code
package spi_pkg;

	typedef logic [2:0] cs_idx_t;

	typedef enum logic [2:0] {
		S_IDLE,
		S_LOAD,
		S_WAIT_READY,
		S_STROBE,
		S_WAIT_RX
	} spi_state_e;

	// command byte 7 value for a 2-byte transfer
	localparam logic [7:0] SPI_SHORT_LEN = 8'd2;

endpackage

/* rtl/cmd_rx.sv */
// Command receiver
// Collects eight bytes from the host stream into the command buffer and
// holds the command valid until the controller reports it done.
module cmd_rx (
	input  logic              clk,
	input  logic              rstn,
	input  logic              i_tvalid,
	input  cmd_pkg::byte_t    i_tdata,
	output logic              o_tready,
	output logic              o_cmd_valid,
	output cmd_pkg::cmd_buf_t o_cmd_buf,
	input  logic              i_cmd_done
);
	import cmd_pkg::*;

	logic [$clog2(CMD_BYTES)-1:0] byte_cnt;
	logic                         accept;

	assign o_tready = !o_cmd_valid; // collecting while nothing pending
	assign accept   = i_tvalid && o_tready;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			byte_cnt    <= '0;
			o_cmd_valid <= 1'b0;
		end else begin
			if (i_cmd_done) begin
				o_cmd_valid <= 1'b0;
			end
			if (accept) begin
				if (byte_cnt == CMD_BYTES - 1) begin
					byte_cnt    <= '0;
					o_cmd_valid <= 1'b1; // eighth byte in
				end else begin
					byte_cnt <= byte_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			o_cmd_buf[byte_cnt] <= i_tdata;
		end
	end

	// counter parked while a command is pending
	a_cnt_range : assert property (@(posedge clk) disable iff (!rstn)
		o_cmd_valid |-> byte_cnt == '0);

endmodule

/* rtl/cmd_ctrl.sv */
// Command controller
// Decodes the opcode of a pending command, issues the fixed replies,
// pulses the PLL reset, runs SPI transfers through the sequencer and
// releases the command once its reply has been taken.
module cmd_ctrl #(
	parameter cmd_pkg::word_t VERSION = 32'd9
) (
	input  logic                 clk,
	input  logic                 rstn,
	input  logic                 i_cmd_valid,
	input  cmd_pkg::cmd_buf_t    i_cmd_buf,
	output logic                 o_cmd_done,
	output logic                 o_spi_start,
	output spi_pkg::cs_idx_t     o_spi_chip,
	output cmd_pkg::byte_t [2:0] o_spi_bytes,
	output logic                 o_spi_short,
	input  logic                 i_spi_done,
	input  cmd_pkg::byte_t       i_spi_rd_byte,
	output logic                 o_reply_load,
	output cmd_pkg::word_t       o_reply_word,
	input  logic                 i_reply_sent,
	output logic                 o_pll_reset
);
	import cmd_pkg::*;
	import spi_pkg::*;

	ctrl_state_e state;
	word_t       fixed_word;
	logic        op_fixed;
	logic        op_known;

	// --------------------
	// opcode decode
	always_comb begin
		fixed_word = REPLY_SPARE;
		op_fixed   = 1'b0;
		op_known   = 1'b1;
		case (i_cmd_buf[0])
			OP_PLL_RESET: begin
				fixed_word = REPLY_PLL_RESET;
				op_fixed   = 1'b1;
			end
			OP_VERSION: begin
				fixed_word = VERSION;
				op_fixed   = 1'b1;
			end
			OP_SPARE: op_fixed = 1'b1;
			OP_SPI:   op_fixed = 1'b0;
			default:  op_known = 1'b0;
		endcase
	end

	// spi arguments straight from the command bytes
	assign o_spi_chip  = i_cmd_buf[1][2:0];
	assign o_spi_bytes = {i_cmd_buf[4], i_cmd_buf[3], i_cmd_buf[2]};
	assign o_spi_short = (i_cmd_buf[7] == SPI_SHORT_LEN);

	assign o_cmd_done = (state == ST_REPLY && i_reply_sent) ||
		(state == ST_DECODE && !op_known); // unknown opcode, no reply

	// --------------------
	// control FSM
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state        <= ST_IDLE;
			o_spi_start  <= 1'b0;
			o_reply_load <= 1'b0;
			o_pll_reset  <= 1'b0;
		end else begin
			o_spi_start  <= 1'b0;
			o_reply_load <= 1'b0;
			o_pll_reset  <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (i_cmd_valid) begin
						state <= ST_DECODE;
					end
				end
				ST_DECODE: begin
					if (op_fixed) begin
						o_reply_load <= 1'b1;
						o_pll_reset  <= (i_cmd_buf[0] == OP_PLL_RESET);
						state        <= ST_REPLY;
					end else if (op_known) begin
						o_spi_start <= 1'b1;
						state       <= ST_SPI_WAIT;
					end else begin
						state <= ST_IDLE;
					end
				end
				ST_SPI_WAIT: begin
					if (i_spi_done) begin
						o_reply_load <= 1'b1;
						state        <= ST_REPLY;
					end
				end
				ST_REPLY: begin
					if (i_reply_sent) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_DECODE) begin
			o_reply_word <= fixed_word;
		end else if (state == ST_SPI_WAIT && i_spi_done) begin
			o_reply_word <= {24'd0, i_spi_rd_byte}; // read byte, zero extended
		end
	end

	// one reply outstanding at a time
	a_no_reload : assert property (@(posedge clk) disable iff (!rstn)
		o_reply_load |-> !i_reply_sent);

endmodule

/* spi/spi_seq.sv */
// SPI transaction sequencer
// Selects one chip, hands 2 or 3 bytes to an external SPI master with a
// data-valid strobe per byte, then waits for the read byte and deselects.
module spi_seq #(
	parameter int NUM_CS = 8
) (
	input  logic                 clk,
	input  logic                 rstn,
	input  logic                 i_start,
	input  spi_pkg::cs_idx_t     i_chip,
	input  cmd_pkg::byte_t [2:0] i_bytes,
	input  logic                 i_short,
	output logic                 o_done,
	output cmd_pkg::byte_t       o_rd_byte,
	input  logic                 i_spi_tx_ready,
	input  logic                 i_spi_rx_dv,
	input  cmd_pkg::byte_t       i_spi_rx,
	output cmd_pkg::byte_t       o_spi_tx,
	output logic                 o_spi_tx_dv,
	output logic [NUM_CS-1:0]    o_spi_cs,
	output spi_pkg::cs_idx_t     o_miso_sel
);
	import cmd_pkg::*;
	import spi_pkg::*;

	spi_state_e  state;
	byte_t [2:0] bytes_q;
	logic        short_q;
	logic [1:0]  idx;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state       <= S_IDLE;
			short_q     <= 1'b0;
			idx         <= '0;
			o_done      <= 1'b0;
			o_spi_tx    <= '0;
			o_spi_tx_dv <= 1'b0;
			o_spi_cs    <= '1;
			o_miso_sel  <= '0;
		end else begin
			o_done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (i_start) begin
						o_spi_cs   <= ~(NUM_CS'(1) << i_chip); // active low select
						o_miso_sel <= i_chip;
						short_q    <= i_short;
						idx        <= '0;
						state      <= S_LOAD;
					end
				end
				S_LOAD: begin
					o_spi_tx <= bytes_q[idx];
					state    <= S_WAIT_READY;
				end
				S_WAIT_READY: begin
					if (i_spi_tx_ready) begin
						o_spi_tx_dv <= 1'b1;
						state       <= S_STROBE;
					end
				end
				S_STROBE: begin
					o_spi_tx_dv <= 1'b0;
					if (idx == 2'd2) begin
						state <= S_WAIT_RX;
					end else begin
						idx   <= short_q ? 2'd2 : idx + 1'b1; // short skips byte 3
						state <= S_LOAD;
					end
				end
				S_WAIT_RX: begin
					if (i_spi_rx_dv) begin
						o_spi_cs <= '1;
						o_done   <= 1'b1;
						state    <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && i_start) begin
			bytes_q <= i_bytes;
		end
		if (state == S_WAIT_RX && i_spi_rx_dv) begin
			o_rd_byte <= i_spi_rx;
		end
	end

	// one chip during a transfer, none when idle
	a_one_cs : assert property (@(posedge clk) disable iff (!rstn)
		$countones(~o_spi_cs) == int'(state != S_IDLE));

endmodule

/* rtl/reply_tx.sv */
// Reply transmitter
// Holds one 32-bit reply beat on the output stream until the host
// accepts it, with full keep and last on every beat.
module reply_tx (
	input  logic           clk,
	input  logic           rstn,
	input  logic           i_load,
	input  cmd_pkg::word_t i_word,
	output logic           o_sent,
	input  logic           i_tready,
	output logic           o_tvalid,
	output cmd_pkg::word_t o_tdata,
	output logic [3:0]     o_tkeep,
	output logic           o_tlast
);

	assign o_tkeep = 4'b1111;
	assign o_tlast = 1'b1;             // single-beat replies
	assign o_sent  = o_tvalid && i_tready;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_tvalid <= 1'b0;
			o_tdata  <= '0;
		end else begin
			if (o_sent) begin
				o_tvalid <= 1'b0;
			end
			if (i_load) begin
				o_tvalid <= 1'b1;
				o_tdata  <= i_word;
			end
		end
	end

	// beat held under back-pressure
	a_hold : assert property (@(posedge clk) disable iff (!rstn)
		o_tvalid && !i_tready |=> o_tvalid && $stable(o_tdata));

endmodule

/* rtl/cmd_proc_top.sv */
// Host command processor top level
// Byte stream in, command decode and SPI access, one-beat replies out
module cmd_proc_top #(
	parameter cmd_pkg::word_t VERSION = 32'd9,
	parameter int             NUM_CS  = 8
) (
	input  logic              clk,
	input  logic              rstn,
	// host command stream
	input  logic              i_tvalid,
	input  cmd_pkg::byte_t    i_tdata,
	output logic              o_tready,
	// reply stream
	input  logic              i_tready,
	output logic              o_tvalid,
	output cmd_pkg::word_t    o_tdata,
	output logic [3:0]        o_tkeep,
	output logic              o_tlast,
	output logic              o_pll_reset,
	// spi master
	input  logic              i_spi_tx_ready,
	input  logic              i_spi_rx_dv,
	input  cmd_pkg::byte_t    i_spi_rx,
	output cmd_pkg::byte_t    o_spi_tx,
	output logic              o_spi_tx_dv,
	output logic [NUM_CS-1:0] o_spi_cs,
	output spi_pkg::cs_idx_t  o_miso_sel
);
	import cmd_pkg::*;
	import spi_pkg::*;

	logic        cmd_valid;
	cmd_buf_t    cmd_buf;
	logic        cmd_done;
	logic        spi_start;
	cs_idx_t     spi_chip;
	byte_t [2:0] spi_bytes;
	logic        spi_short;
	logic        spi_done;
	byte_t       spi_rd_byte;
	logic        reply_load;
	word_t       reply_word;
	logic        reply_sent;

	cmd_rx cmd_rx_inst (
		.clk(clk), .rstn(rstn),
		.i_tvalid(i_tvalid), .i_tdata(i_tdata), .o_tready(o_tready),
		.o_cmd_valid(cmd_valid), .o_cmd_buf(cmd_buf), .i_cmd_done(cmd_done)
	);

	cmd_ctrl #(.VERSION(VERSION)) cmd_ctrl_inst (
		.clk(clk), .rstn(rstn),
		.i_cmd_valid(cmd_valid), .i_cmd_buf(cmd_buf), .o_cmd_done(cmd_done),
		.o_spi_start(spi_start), .o_spi_chip(spi_chip), .o_spi_bytes(spi_bytes),
		.o_spi_short(spi_short), .i_spi_done(spi_done), .i_spi_rd_byte(spi_rd_byte),
		.o_reply_load(reply_load), .o_reply_word(reply_word),
		.i_reply_sent(reply_sent), .o_pll_reset(o_pll_reset)
	);

	spi_seq #(.NUM_CS(NUM_CS)) spi_seq_inst (
		.clk(clk), .rstn(rstn),
		.i_start(spi_start), .i_chip(spi_chip), .i_bytes(spi_bytes),
		.i_short(spi_short), .o_done(spi_done), .o_rd_byte(spi_rd_byte),
		.i_spi_tx_ready(i_spi_tx_ready), .i_spi_rx_dv(i_spi_rx_dv), .i_spi_rx(i_spi_rx),
		.o_spi_tx(o_spi_tx), .o_spi_tx_dv(o_spi_tx_dv), .o_spi_cs(o_spi_cs),
		.o_miso_sel(o_miso_sel)
	);

	reply_tx reply_tx_inst (
		.clk(clk), .rstn(rstn),
		.i_load(reply_load), .i_word(reply_word), .o_sent(reply_sent),
		.i_tready(i_tready), .o_tvalid(o_tvalid), .o_tdata(o_tdata),
		.o_tkeep(o_tkeep), .o_tlast(o_tlast)
	);

endmodule

/* testbench/tb_cmd_proc.sv */
// Testbench for the host command processor
// Host stream and SPI master models around the DUT, with concurrent
// assertions on reply beats, PLL reset, chip select and transmit bytes
module tb_cmd_proc;
	timeunit 1ns;
	timeprecision 1ps;
	import cmd_pkg::*;
	import spi_pkg::*;

	localparam int TIMEOUT = 200;

	logic       clk = 1'b0;
	logic       rstn, i_tvalid, i_tready, i_spi_tx_ready;
	byte_t      i_tdata;
	logic       i_spi_rx_dv = 1'b0;
	byte_t      i_spi_rx = '0;
	logic       o_tready, o_tvalid, o_tlast, o_pll_reset, o_spi_tx_dv;
	word_t      o_tdata;
	logic [3:0] o_tkeep;
	byte_t      o_spi_tx;
	logic [7:0] o_spi_cs;
	cs_idx_t    o_miso_sel;

	// expected behaviour
	word_t    exp_word = '0;
	logic     reply_expected = 1'b0;
	logic     pll_expected = 1'b0;
	cs_idx_t  exp_chip = '0;
	byte_t    exp_tx [0:63];
	int       tx_cnt = 0;
	int       tx_idx = 0;
	byte_t    last_tx = '0;
	int       rx_delay = 0;
	int       pll_pulses = 0;
	int       errors = 0;
	int       err_mark = 0;
	int       tests = 0;
	cmd_buf_t cmd;

	always #50 clk = ~clk;

	cmd_proc_top #(.VERSION(32'd9), .NUM_CS(8)) cmd_proc_top_inst (
		.clk(clk), .rstn(rstn),
		.i_tvalid(i_tvalid), .i_tdata(i_tdata), .o_tready(o_tready),
		.i_tready(i_tready), .o_tvalid(o_tvalid), .o_tdata(o_tdata),
		.o_tkeep(o_tkeep), .o_tlast(o_tlast), .o_pll_reset(o_pll_reset),
		.i_spi_tx_ready(i_spi_tx_ready), .i_spi_rx_dv(i_spi_rx_dv), .i_spi_rx(i_spi_rx),
		.o_spi_tx(o_spi_tx), .o_spi_tx_dv(o_spi_tx_dv), .o_spi_cs(o_spi_cs),
		.o_miso_sel(o_miso_sel)
	);

	// --------------------
	// spi master model
	always @(posedge clk) begin
		if (o_spi_tx_dv) begin
			tx_idx  <= tx_idx + 1;
			last_tx <= o_spi_tx;
		end
		if (o_pll_reset) begin
			pll_pulses <= pll_pulses + 1;
		end
	end

	always @(negedge clk) begin
		if (o_spi_tx_dv && tx_idx + 1 == tx_cnt) begin
			rx_delay <= 3; // last strobe of the transfer
		end else if (rx_delay != 0) begin
			rx_delay <= rx_delay - 1;
		end
		i_spi_rx_dv <= (rx_delay == 1);
		i_spi_rx    <= last_tx ^ 8'hA5;
	end

	// --------------------
	// checks
	a_reset_state : assert property (@(negedge clk) !rstn |->
		!o_tvalid && !o_spi_tx_dv && !o_pll_reset && o_spi_cs == 8'hFF && o_tready)
		else log_mismatch("outputs not at their reset values");
	a_reply_beat : assert property (@(posedge clk) disable iff (!rstn) o_tvalid |->
		reply_expected && o_tdata == exp_word && o_tkeep == 4'hF && o_tlast)
		else log_mismatch("unexpected reply beat");
	a_reply_hold : assert property (@(posedge clk) disable iff (!rstn)
		o_tvalid && !i_tready |=> o_tvalid && $stable(o_tdata))
		else log_mismatch("reply changed under back-pressure");
	a_no_accept : assert property (@(posedge clk) disable iff (!rstn) o_tvalid |-> !o_tready)
		else log_mismatch("input ready while a reply is pending");
	a_pll_pulse : assert property (@(posedge clk) disable iff (!rstn)
		o_pll_reset |-> pll_expected ##1 (!o_pll_reset && o_tvalid))
		else log_mismatch("bad PLL reset pulse");
	a_chip_select : assert property (@(posedge clk) disable iff (!rstn) o_spi_cs != 8'hFF |->
		!o_spi_cs[exp_chip] && $countones(o_spi_cs) == 7 && o_miso_sel == exp_chip)
		else log_mismatch("wrong chip select or MISO select");
	a_tx_byte : assert property (@(posedge clk) disable iff (!rstn)
		o_spi_tx_dv |-> tx_idx < tx_cnt && o_spi_tx == exp_tx[tx_idx])
		else log_mismatch("wrong SPI transmit byte");

	task automatic log_mismatch(input string msg);
		errors++;
		$display("Mismatch at %0t: %s", $time, msg);
	endtask

	task automatic report_test(input string name);
		tests++;
		$display("test %0d %s: %s", tests, name, errors == err_mark ? "ok" : "FAILED");
		err_mark = errors;
	endtask

	task automatic send_cmd(input cmd_buf_t c);
		int t;
		for (int k = 0; k < CMD_BYTES; k++) begin
			i_tvalid = 1'b1;
			i_tdata  = c[k];
			t = 0;
			while (!o_tready && t < TIMEOUT) begin
				@(negedge clk);
				t++;
			end
			if (!o_tready) begin
				errors++;
				$display("Timeout: command byte %0d was never accepted", k);
			end
			@(negedge clk);
		end
		i_tvalid = 1'b0;
	endtask

	task automatic take_reply(input bit stall);
		int t;
		bit taken;
		t     = 0;
		taken = 1'b0;
		while (!taken && t < TIMEOUT) begin
			i_tready = stall ? (t > 6 && $urandom_range(3, 0) == 0) : 1'b1;
			taken    = o_tvalid && i_tready; // handshake on the next edge
			@(negedge clk);
			t++;
		end
		i_tready = 1'b0;
		if (!taken) begin
			errors++;
			$display("Timeout: no reply beat was taken");
		end
	endtask

	task automatic wait_tready();
		int t;
		t = 0;
		while (!o_tready && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (!o_tready) begin
			errors++;
			$display("Timeout: input stream never became ready again");
		end
	endtask

	task automatic run_fixed(input opcode_e op, input word_t word, input bit stall);
		cmd            = '0;
		cmd[0]         = op;
		exp_word       = word;
		reply_expected = 1'b1;
		pll_expected   = (op == OP_PLL_RESET);
		send_cmd(cmd);
		i_tvalid = stall; // extra byte offered while the reply waits
		take_reply(stall);
		i_tvalid       = 1'b0;
		reply_expected = 1'b0;
		pll_expected   = 1'b0;
	endtask

	task automatic run_spi(input bit short_xfer);
		cs_idx_t chip;
		chip   = cs_idx_t'($urandom_range(7, 0));
		cmd    = '0;
		cmd[0] = OP_SPI;
		cmd[1] = {5'd0, chip};
		cmd[2] = byte_t'($urandom);
		cmd[3] = byte_t'($urandom);
		cmd[4] = byte_t'($urandom);
		cmd[7] = short_xfer ? 8'd2 : 8'd3;
		exp_chip       = chip;
		exp_tx[tx_cnt] = cmd[2];
		if (!short_xfer) begin
			exp_tx[tx_cnt + 1] = cmd[3];
		end
		exp_tx[tx_cnt + (short_xfer ? 1 : 2)] = cmd[4];
		tx_cnt         = tx_cnt + (short_xfer ? 2 : 3);
		exp_word       = {24'd0, cmd[4] ^ 8'hA5}; // master echoes last byte
		reply_expected = 1'b1;
		send_cmd(cmd);
		take_reply(1'b0);
		reply_expected = 1'b0;
		assert (tx_idx == tx_cnt) else log_mismatch("wrong number of SPI bytes sent");
	endtask

	// --------------------
	// test sequence
	initial begin
		void'($urandom(9));
		rstn           = 1'b0;
		i_tvalid       = 1'b0;
		i_tdata        = '0;
		i_tready       = 1'b0;
		i_spi_tx_ready = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;
		report_test("reset values");
		run_fixed(OP_VERSION, 32'd9, 1'b0);
		report_test("version reply");
		run_fixed(OP_SPARE, 32'd19, 1'b0);
		report_test("spare reply");
		run_fixed(OP_PLL_RESET, 32'd33, 1'b0);
		assert (pll_pulses == 1) else log_mismatch("PLL reset pulse count is not one");
		report_test("pll reset");
		for (int n = 0; n < 4; n++) begin
			run_spi(n[0]);
			report_test(n[0] ? "spi short transfer" : "spi long transfer");
		end
		run_fixed(OP_VERSION, 32'd9, 1'b1);
		report_test("reply back-pressure");
		cmd    = '0;
		cmd[0] = 8'h07; // not an opcode
		send_cmd(cmd);
		wait_tready();
		report_test("unknown opcode");
		run_fixed(OP_VERSION, 32'd9, 1'b0);
		report_test("version after unknown");
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* src.f */
common/cmd_pkg.sv
common/spi_pkg.sv
rtl/cmd_rx.sv
rtl/cmd_ctrl.sv
spi/spi_seq.sv
rtl/reply_tx.sv
rtl/cmd_proc_top.sv
testbench/tb_cmd_proc.sv
